// ==== Bender.yml ====
package:
  name: rcb_regs

sources:
  - hw/rcb_pkg.sv
  - hw/rcb_status_sync.sv
  - hw/rcb_ctrl_regs.sv
  - hw/rcb_read_mux.sv
  - hw/rcb_tick_gen.sv
  - hw/rcb_fan_pwm.sv
  - hw/rcb_fan_tacho.sv
  - hw/rcb_top.sv
  - target: test
    files:
      - test/tb_rcb_top.sv

// ==== hw/rcb_ctrl_regs.sv ====
`default_nettype none

module rcb_ctrl_regs (
	input  wire logic               clk_100m,
	input  wire logic               rst_n_syn,
	input  wire rcb_pkg::host_bus_t bus,
	output rcb_pkg::ctrl_t          ctrl,
	output logic                    diag_activation
);
	import rcb_pkg::*;

	//////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			ctrl          <= '0;
			ctrl.diag_led <= DIAG_LED_RESET;
		end
		else if (bus.wr)
		begin
			case (bus.addr)
				ADDR_FPGA_DRAPE_EM_OPEN:
				begin
					ctrl.right_em_open <= bus.wdata[8];
					ctrl.left_em_open  <= bus.wdata[0];
				end
				// Only the arm bit is kept here
				ADDR_FPGA_ESTOP_ACTIVATION:
					ctrl.diag_arm <= bus.wdata[31];
				ADDR_FPGA_ESTOP_DIAGNOSTIC:
					ctrl.diag_key <= bus.wdata[15:0];
				ADDR_FPGA_ESTOP_OPEN:
					ctrl.estop_open <= bus.wdata[0];
				ADDR_FPGA_DIAGNOSTIC_LEDS:
					ctrl.diag_led <= bus.wdata[7:0];
				ADDR_FPGA_FAN1_PWM:
					ctrl.fan1_duty <= bus.wdata[7:0];
				ADDR_FPGA_FAN2_PWM:
					ctrl.fan2_duty <= bus.wdata[7:0];
				default:
				begin
				end
			endcase
		end
	end

	// Diagnostic close needs arm bit and the key
	assign diag_activation = ctrl.diag_arm && (ctrl.diag_key == ESTOP_DIAG_KEY);

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// A rise needs a host write that sets the arm bit or stores the matching key
	a_diag_rise_keyed: assert property (
		@(posedge clk_100m) disable iff (!rst_n_syn)
		$rose(diag_activation) |->
			$past(bus.wr) &&
			(($past(bus.addr) == ADDR_FPGA_ESTOP_ACTIVATION && $past(bus.wdata[31])) ||
			($past(bus.addr) == ADDR_FPGA_ESTOP_DIAGNOSTIC &&
				$past(bus.wdata[15:0]) == ESTOP_DIAG_KEY))
	) else $error("diag_activation rose without a keyed e-stop write");

endmodule

`default_nettype wire

// ==== hw/rcb_fan_pwm.sv ====
`default_nettype none

module rcb_fan_pwm (
	input  wire logic           clk_100m,
	input  wire logic           rst_n_syn,
	input  wire logic           tick,
	input  wire rcb_pkg::duty_t duty,
	output logic                pwm
);
	import rcb_pkg::*;

	pwm_state_t state;
	pwm_phase_t phase;
	duty_t      duty_q;
	pwm_phase_t level;
	logic       full;

	// Duty latched once per period at phase 0
	assign level = {duty_q, 2'b00};
	assign full  = (duty_q == 8'hFF);

	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			state  <= PWM_IDLE;
			phase  <= '0;
			duty_q <= '0;
			pwm    <= 1'b0;
		end
		else if (tick)
		begin
			if (phase == pwm_phase_t'(PWM_PERIOD - 1))
				phase <= '0;
			else
				phase <= phase + 1'b1;

			if (phase == '0)
			begin
				duty_q <= duty;
				state  <= (duty != '0) ? PWM_PULSE : PWM_IDLE;
				pwm    <= (duty != '0);
			end
			else
			begin
				case (state)
					PWM_PULSE:
					begin
						// Full duty never drops within the period
						if (!(phase < level || full))
						begin
							state <= PWM_IDLE;
							pwm   <= 1'b0;
						end
					end
					default:
						pwm <= 1'b0;
				endcase
			end
		end
	end

	a_zero_duty_low: assert property (
		@(posedge clk_100m) disable iff (!rst_n_syn)
		(tick && duty_q == '0) |-> !pwm
	) else $error("pwm high with zero latched duty");

endmodule

`default_nettype wire

// ==== hw/rcb_fan_tacho.sv ====
`default_nettype none

module rcb_fan_tacho (
	input  wire logic        clk_100m,
	input  wire logic        rst_n_syn,
	input  wire logic        tick,
	input  wire logic        meas_pulse,
	input  wire logic        tacho_in,
	output rcb_pkg::tacho_t  result
);
	import rcb_pkg::*;

	logic         tacho_meta;
	logic         tacho_sync;
	logic         tacho_prev;
	tacho_count_t edge_cnt;

	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			tacho_meta <= 1'b0;
			tacho_sync <= 1'b0;
			tacho_prev <= 1'b0;
			edge_cnt   <= '0;
			result     <= '0;
		end
		else
		begin
			tacho_meta <= tacho_in;
			tacho_sync <= tacho_meta;
			tacho_prev <= tacho_sync;
			// Window end wins over a coinciding edge
			if (tick && meas_pulse)
			begin
				result.count      <= edge_cnt;
				result.sample_num <= result.sample_num + 1'b1;
				edge_cnt          <= '0;
			end
			else if (tacho_sync && !tacho_prev)
				edge_cnt <= edge_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/rcb_pkg.sv ====
`default_nettype none

package rcb_pkg;

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////

	typedef logic [31:0] reg_word_t;
	typedef logic [15:0] reg_addr_t;
	typedef logic [7:0]  duty_t;
	typedef logic [9:0]  pwm_phase_t;
	typedef logic [15:0] tacho_count_t;
	typedef logic [7:0]  sample_num_t;

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////

	// One host access, strobe is a single cycle
	typedef struct packed {
		reg_addr_t addr;
		reg_word_t wdata;
		logic      wr;
	} host_bus_t;

	typedef struct packed {
		logic        pow;
		logic [7:0]  buttons;
		logic [1:0]  drape_sw_state;
		logic [1:0]  drape_em_state;
		logic [11:0] drape_sensor;
	} status_t;

	typedef struct packed {
		logic        right_em_open;
		logic        left_em_open;
		logic        estop_open;
		logic        diag_arm;
		logic [15:0] diag_key;
		logic [7:0]  diag_led;
		duty_t       fan1_duty;
		duty_t       fan2_duty;
	} ctrl_t;

	typedef struct packed {
		tacho_count_t count;
		sample_num_t  sample_num;
	} tacho_t;

	typedef enum logic {
		PWM_IDLE  = 1'b0,
		PWM_PULSE = 1'b1
	} pwm_state_t;

	//////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////

	// Identity, build stamp fields are set at release
	localparam logic [7:0] FPGA_MAJOR_VER = 8'h01;
	localparam logic [7:0] FPGA_REV       = 8'h00;
	localparam logic [7:0] FPGA_REV_YEAR  = 8'h00;
	localparam logic [7:0] FPGA_REV_MONTH = 8'h00;
	localparam logic [7:0] FPGA_REV_DAY   = 8'h00;
	localparam logic [7:0] FPGA_REV_HOUR  = 8'h00;

	localparam logic [15:0] ESTOP_DIAG_KEY = 16'hABCD;

	// One second of 1 MHz ticks
	localparam int unsigned FAN_TACHO_MEAS_TICKS = 1_000_000;
	localparam int unsigned PWM_PERIOD           = 1024;

	localparam logic [7:0] DIAG_LED_RESET = 8'hFF;
	localparam reg_word_t  READ_INVALID   = '1;

	// Register map
	localparam reg_addr_t ADDR_FPGA_VER              = 16'h0000;
	localparam reg_addr_t ADDR_FPGA_REV_DATA         = 16'h0004;
	localparam reg_addr_t ADDR_FPGA_POW_DIAG         = 16'h0008;
	localparam reg_addr_t ADDR_FPGA_BUTTONS          = 16'h000C;
	localparam reg_addr_t ADDR_FPGA_DRAPE_SENSOR     = 16'h0010;
	localparam reg_addr_t ADDR_FPGA_DRAPE_SW_STATE   = 16'h0014;
	localparam reg_addr_t ADDR_FPGA_DRAPE_EM_STATE   = 16'h0018;
	localparam reg_addr_t ADDR_FPGA_DRAPE_EM_OPEN    = 16'h001C;
	localparam reg_addr_t ADDR_FPGA_ESTOP_ACTIVATION = 16'h0020;
	localparam reg_addr_t ADDR_FPGA_ESTOP_DIAGNOSTIC = 16'h0024;
	localparam reg_addr_t ADDR_FPGA_ESTOP_OPEN       = 16'h0028;
	localparam reg_addr_t ADDR_FPGA_DIAGNOSTIC_LEDS  = 16'h002C;
	localparam reg_addr_t ADDR_FPGA_FAN1_TACHO       = 16'h0030;
	localparam reg_addr_t ADDR_FPGA_FAN1_PWM         = 16'h0034;
	localparam reg_addr_t ADDR_FPGA_FAN2_TACHO       = 16'h0038;
	localparam reg_addr_t ADDR_FPGA_FAN2_PWM         = 16'h003C;

endpackage

`default_nettype wire

// ==== hw/rcb_read_mux.sv ====
`default_nettype none

module rcb_read_mux (
	input  wire rcb_pkg::reg_addr_t addr,
	input  wire rcb_pkg::status_t   status,
	input  wire rcb_pkg::ctrl_t     ctrl,
	input  wire rcb_pkg::tacho_t    tacho1,
	input  wire rcb_pkg::tacho_t    tacho2,
	output rcb_pkg::reg_word_t      data_miso
);
	import rcb_pkg::*;

	// Purely combinational, no clock in this block
	always_comb
	begin
		case (addr)
			ADDR_FPGA_VER:
				data_miso = {16'h0000, FPGA_MAJOR_VER, FPGA_REV};
			ADDR_FPGA_REV_DATA:
				data_miso = {FPGA_REV_YEAR, FPGA_REV_MONTH, FPGA_REV_DAY, FPGA_REV_HOUR};
			ADDR_FPGA_POW_DIAG:
				data_miso = {31'b0, status.pow};
			ADDR_FPGA_BUTTONS:
				data_miso = {24'b0, status.buttons};
			// Sensors split in two groups of six
			ADDR_FPGA_DRAPE_SENSOR:
				data_miso = {18'b0, status.drape_sensor[11:6], 2'b00,
					status.drape_sensor[5:0]};
			ADDR_FPGA_DRAPE_SW_STATE:
				data_miso = {30'b0, status.drape_sw_state};
			ADDR_FPGA_DRAPE_EM_STATE:
				data_miso = {30'b0, status.drape_em_state};
			ADDR_FPGA_DRAPE_EM_OPEN:
				data_miso = {23'b0, ctrl.right_em_open, 7'b0, ctrl.left_em_open};
			ADDR_FPGA_ESTOP_ACTIVATION:
				data_miso = {ctrl.diag_arm, 31'b0};
			ADDR_FPGA_ESTOP_DIAGNOSTIC:
				data_miso = {16'h0000, ctrl.diag_key};
			ADDR_FPGA_ESTOP_OPEN:
				data_miso = {31'b0, ctrl.estop_open};
			ADDR_FPGA_DIAGNOSTIC_LEDS:
				data_miso = {24'b0, ctrl.diag_led};
			// Tacho words carry sample number above the count
			ADDR_FPGA_FAN1_TACHO:
				data_miso = {8'h00, tacho1.sample_num, tacho1.count};
			ADDR_FPGA_FAN1_PWM:
				data_miso = {24'b0, ctrl.fan1_duty};
			ADDR_FPGA_FAN2_TACHO:
				data_miso = {8'h00, tacho2.sample_num, tacho2.count};
			ADDR_FPGA_FAN2_PWM:
				data_miso = {24'b0, ctrl.fan2_duty};
			default:
				data_miso = READ_INVALID;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rcb_status_sync.sv ====
`default_nettype none

module rcb_status_sync (
	input  wire logic        clk_100m,
	input  wire logic        rst_n_syn,
	input  wire logic        pow,
	input  wire logic [7:0]  fpga_buttons,
	input  wire logic [1:0]  drape_sw_state,
	input  wire logic [1:0]  drape_em_state,
	input  wire logic [11:0] drape_sensor,
	output rcb_pkg::status_t status
);
	import rcb_pkg::*;

	status_t raw;
	status_t meta;

	// Gather the raw pins, all asynchronous to clk_100m
	assign raw = '{
		pow:            pow,
		buttons:        fpga_buttons,
		drape_sw_state: drape_sw_state,
		drape_em_state: drape_em_state,
		drape_sensor:   drape_sensor
	};

	// Two flop stages against metastability
	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			meta   <= '0;
			status <= '0;
		end
		else
		begin
			meta   <= raw;
			status <= meta;
		end
	end

endmodule

`default_nettype wire

// ==== hw/rcb_tick_gen.sv ====
`default_nettype none

module rcb_tick_gen #(
	parameter int unsigned meas_ticks = rcb_pkg::FAN_TACHO_MEAS_TICKS
) (
	input  wire logic clk_100m,
	input  wire logic rst_n_syn,
	input  wire logic clk_1m,
	output logic      tick,
	output logic      meas_pulse
);
	typedef logic [$clog2(meas_ticks + 2) - 1:0] win_cnt_t;

	logic     clk_1m_s;
	logic     clk_1m_prev;
	logic     rise;
	win_cnt_t win_cnt;

	// Held high in reset so a high clk_1m is not taken as an edge
	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			clk_1m_s    <= 1'b1;
			clk_1m_prev <= 1'b1;
		end
		else
		begin
			clk_1m_s    <= clk_1m;
			clk_1m_prev <= clk_1m_s;
		end
	end

	assign rise = clk_1m_s && !clk_1m_prev;

	// Window counter runs 0..meas_ticks
	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			tick       <= 1'b0;
			meas_pulse <= 1'b0;
			win_cnt    <= '0;
		end
		else
		begin
			tick       <= rise;
			meas_pulse <= rise && (win_cnt == win_cnt_t'(meas_ticks));
			if (rise)
			begin
				if (win_cnt == win_cnt_t'(meas_ticks))
					win_cnt <= '0;
				else
					win_cnt <= win_cnt + 1'b1;
			end
		end
	end

	a_tick_single: assert property (
		@(posedge clk_100m) disable iff (!rst_n_syn)
		tick |=> !tick
	) else $error("tick high for two cycles in a row");

endmodule

`default_nettype wire

// ==== hw/rcb_top.sv ====
`default_nettype none

module rcb_top #(
	parameter int unsigned meas_ticks = rcb_pkg::FAN_TACHO_MEAS_TICKS
) (
	input  wire logic                clk_100m,
	input  wire logic                rst_n_syn,
	input  wire logic                clk_1m,
	// Host side
	input  wire rcb_pkg::reg_addr_t  addr,
	input  wire rcb_pkg::reg_word_t  data_mosi,
	input  wire logic                data_mosi_rdy,
	output rcb_pkg::reg_word_t       data_miso,
	// Status pins
	input  wire logic                pow,
	input  wire logic [7:0]          fpga_buttons,
	input  wire logic [1:0]          drape_sw_state,
	input  wire logic [1:0]          drape_em_state,
	input  wire logic [11:0]         drape_sensor,
	// Control pins
	output logic                     right_drape_em_open,
	output logic                     left_drape_em_open,
	output logic                     estop_open,
	output logic                     diag_activation,
	output logic [7:0]               diagnostic_led,
	// Fans
	input  wire logic                fan1_tacho,
	input  wire logic                fan2_tacho,
	output logic                     fan1_pwm,
	output logic                     fan2_pwm
);
	import rcb_pkg::*;

	host_bus_t bus;
	status_t   status;
	ctrl_t     ctrl;
	tacho_t    tacho1;
	tacho_t    tacho2;
	logic      tick;
	logic      meas_pulse;

	assign bus = '{addr: addr, wdata: data_mosi, wr: data_mosi_rdy};

	assign right_drape_em_open = ctrl.right_em_open;
	assign left_drape_em_open  = ctrl.left_em_open;
	assign estop_open          = ctrl.estop_open;
	assign diagnostic_led      = ctrl.diag_led;

	rcb_status_sync i_status_sync (
		.clk_100m       (clk_100m),
		.rst_n_syn      (rst_n_syn),
		.pow            (pow),
		.fpga_buttons   (fpga_buttons),
		.drape_sw_state (drape_sw_state),
		.drape_em_state (drape_em_state),
		.drape_sensor   (drape_sensor),
		.status         (status)
	);

	rcb_ctrl_regs i_ctrl_regs (
		.clk_100m        (clk_100m),
		.rst_n_syn       (rst_n_syn),
		.bus             (bus),
		.ctrl            (ctrl),
		.diag_activation (diag_activation)
	);

	rcb_read_mux i_read_mux (
		.addr      (addr),
		.status    (status),
		.ctrl      (ctrl),
		.tacho1    (tacho1),
		.tacho2    (tacho2),
		.data_miso (data_miso)
	);

	rcb_tick_gen #(
		.meas_ticks (meas_ticks)
	) i_tick_gen (
		.clk_100m   (clk_100m),
		.rst_n_syn  (rst_n_syn),
		.clk_1m     (clk_1m),
		.tick       (tick),
		.meas_pulse (meas_pulse)
	);

	//////////////////////////////////////////////////
	// Fan channels
	//////////////////////////////////////////////////

	rcb_fan_pwm i_fan1_pwm (
		.clk_100m  (clk_100m),
		.rst_n_syn (rst_n_syn),
		.tick      (tick),
		.duty      (ctrl.fan1_duty),
		.pwm       (fan1_pwm)
	);

	rcb_fan_pwm i_fan2_pwm (
		.clk_100m  (clk_100m),
		.rst_n_syn (rst_n_syn),
		.tick      (tick),
		.duty      (ctrl.fan2_duty),
		.pwm       (fan2_pwm)
	);

	rcb_fan_tacho i_fan1_tacho (
		.clk_100m   (clk_100m),
		.rst_n_syn  (rst_n_syn),
		.tick       (tick),
		.meas_pulse (meas_pulse),
		.tacho_in   (fan1_tacho),
		.result     (tacho1)
	);

	rcb_fan_tacho i_fan2_tacho (
		.clk_100m   (clk_100m),
		.rst_n_syn  (rst_n_syn),
		.tick       (tick),
		.meas_pulse (meas_pulse),
		.tacho_in   (fan2_tacho),
		.result     (tacho2)
	);

endmodule

`default_nettype wire

// ==== sources.f ====
hw/rcb_pkg.sv
hw/rcb_status_sync.sv
hw/rcb_ctrl_regs.sv
hw/rcb_read_mux.sv
hw/rcb_tick_gen.sv
hw/rcb_fan_pwm.sv
hw/rcb_fan_tacho.sv
hw/rcb_top.sv
test/tb_rcb_top.sv

// ==== test/tb_rcb_top.sv ====
`default_nettype none

module tb_rcb_top;
	timeunit 1ns;
	timeprecision 1ps;

	import rcb_pkg::*;

	localparam int MEAS_TICKS = 200;
	// One tacho window in clk_100m cycles at 10 cycles per clk_1m period
	localparam int WIN_CYCLES = (MEAS_TICKS + 1) * 10;

	logic        clk_100m = 1'b0;
	logic        rst_n_syn;
	logic        clk_1m;
	int          clk_1m_div;
	reg_addr_t   addr;
	reg_word_t   data_mosi;
	logic        data_mosi_rdy;
	reg_word_t   data_miso;
	logic        pow;
	logic [7:0]  fpga_buttons;
	logic [1:0]  drape_sw_state;
	logic [1:0]  drape_em_state;
	logic [11:0] drape_sensor;
	logic        right_drape_em_open;
	logic        left_drape_em_open;
	logic        estop_open;
	logic        diag_activation;
	logic [7:0]  diagnostic_led;
	logic        fan1_tacho;
	logic        fan2_tacho;
	logic        fan1_pwm;
	logic        fan2_pwm;

	// Reference model of the writable fields
	logic        exp_right;
	logic        exp_left;
	logic        exp_estop;
	logic        exp_arm;
	logic [15:0] exp_key;
	logic [7:0]  exp_led;
	logic        pins_en;
	logic [11:0] pins_seen;
	logic [11:0] pins_exp;

	logic        miso_en;
	reg_word_t   exp_miso;
	logic        val_en;
	string       val_name;
	reg_word_t   val_got;
	reg_word_t   val_exp;

	int          err_cnt;
	int          tests_run;
	int          tests_failed;
	int          test_err_base;
	string       test_name;
	integer      seed = 32'hcdb53ad3;

	always #5 clk_100m = ~clk_100m;

	// 10 MHz reference
	always @(negedge clk_100m)
	begin
		if (clk_1m_div == 4)
		begin
			clk_1m_div <= 0;
			clk_1m     <= ~clk_1m;
		end
		else
			clk_1m_div <= clk_1m_div + 1;
	end

	rcb_top #(
		.meas_ticks (MEAS_TICKS)
	) i_dut (
		.clk_100m            (clk_100m),
		.rst_n_syn           (rst_n_syn),
		.clk_1m              (clk_1m),
		.addr                (addr),
		.data_mosi           (data_mosi),
		.data_mosi_rdy       (data_mosi_rdy),
		.data_miso           (data_miso),
		.pow                 (pow),
		.fpga_buttons        (fpga_buttons),
		.drape_sw_state      (drape_sw_state),
		.drape_em_state      (drape_em_state),
		.drape_sensor        (drape_sensor),
		.right_drape_em_open (right_drape_em_open),
		.left_drape_em_open  (left_drape_em_open),
		.estop_open          (estop_open),
		.diag_activation     (diag_activation),
		.diagnostic_led      (diagnostic_led),
		.fan1_tacho          (fan1_tacho),
		.fan2_tacho          (fan2_tacho),
		.fan1_pwm            (fan1_pwm),
		.fan2_pwm            (fan2_pwm)
	);

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Order right, left, estop, diag, leds
	assign pins_seen = {right_drape_em_open, left_drape_em_open, estop_open,
		diag_activation, diagnostic_led};
	// Diagnostic close only with arm bit and the right key
	assign pins_exp = {exp_right, exp_left, exp_estop,
		exp_arm && (exp_key == ESTOP_DIAG_KEY), exp_led};

	a_pins: assert property (@(negedge clk_100m) pins_en |-> pins_seen == pins_exp)
	else
	begin
		err_cnt++;
		$display("Error: {right_drape_em_open, left_drape_em_open, estop_open, %s = %h, expected %h",
			"diag_activation, diagnostic_led}", $sampled(pins_seen), $sampled(pins_exp));
	end

	a_read: assert property (@(negedge clk_100m) miso_en |-> data_miso == exp_miso)
	else
	begin
		err_cnt++;
		$display("Error: data_miso = %h, expected %h (addr %h)", $sampled(data_miso),
			$sampled(exp_miso), $sampled(addr));
	end

	a_value: assert property (@(negedge clk_100m) val_en |-> val_got == val_exp)
	else
	begin
		err_cnt++;
		$display("Error: %s = %h, expected %h", val_name, $sampled(val_got), $sampled(val_exp));
	end

	//////////////////////////////////////////////////
	// Helpers that start and end on a falling edge
	//////////////////////////////////////////////////

	task automatic start_test(input string name);
		test_name     = name;
		test_err_base = err_cnt;
	endtask

	task automatic end_test();
		// Let pending assertion actions run first
		@(posedge clk_100m);
		tests_run++;
		if (err_cnt == test_err_base)
			$display("test %s: passed", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: failed, %0d errors", test_name, err_cnt - test_err_base);
		end
		@(negedge clk_100m);
	endtask

	task automatic timeout_error(input string what);
		err_cnt++;
		$display("Timeout: %s", what);
	endtask

	// Bits each writable register keeps
	function automatic reg_word_t field_mask(input reg_addr_t a);
		case (a)
			ADDR_FPGA_DRAPE_EM_OPEN:    return 32'h0000_0101;
			ADDR_FPGA_ESTOP_ACTIVATION: return 32'h8000_0000;
			ADDR_FPGA_ESTOP_DIAGNOSTIC: return 32'h0000_FFFF;
			ADDR_FPGA_ESTOP_OPEN:       return 32'h0000_0001;
			ADDR_FPGA_DIAGNOSTIC_LEDS:  return 32'h0000_00FF;
			ADDR_FPGA_FAN1_PWM:         return 32'h0000_00FF;
			ADDR_FPGA_FAN2_PWM:         return 32'h0000_00FF;
			default:                    return 32'h0000_0000;
		endcase
	endfunction

	function automatic reg_addr_t writable_addr(input int i);
		case (i)
			0:       return ADDR_FPGA_DRAPE_EM_OPEN;
			1:       return ADDR_FPGA_ESTOP_ACTIVATION;
			2:       return ADDR_FPGA_ESTOP_DIAGNOSTIC;
			3:       return ADDR_FPGA_ESTOP_OPEN;
			4:       return ADDR_FPGA_DIAGNOSTIC_LEDS;
			5:       return ADDR_FPGA_FAN1_PWM;
			default: return ADDR_FPGA_FAN2_PWM;
		endcase
	endfunction

	// Packed word from the status pins as currently driven
	function automatic reg_word_t status_expect(input reg_addr_t a);
		reg_word_t e;
		e = '0;
		case (a)
			ADDR_FPGA_POW_DIAG:       e[0] = pow;
			ADDR_FPGA_BUTTONS:        e[7:0] = fpga_buttons;
			ADDR_FPGA_DRAPE_SW_STATE: e[1:0] = drape_sw_state;
			ADDR_FPGA_DRAPE_EM_STATE: e[1:0] = drape_em_state;
			default:
			begin
				e[13:8] = drape_sensor[11:6];
				e[5:0]  = drape_sensor[5:0];
			end
		endcase
		return e;
	endfunction

	// Strobe one write and update the model in the same cycle
	task automatic write_reg(input reg_addr_t a, input reg_word_t d);
		addr          = a;
		data_mosi     = d;
		data_mosi_rdy = 1'b1;
		case (a)
			ADDR_FPGA_DRAPE_EM_OPEN:
			begin
				exp_right = d[8];
				exp_left  = d[0];
			end
			ADDR_FPGA_ESTOP_ACTIVATION: exp_arm = d[31];
			ADDR_FPGA_ESTOP_DIAGNOSTIC: exp_key = d[15:0];
			ADDR_FPGA_ESTOP_OPEN:       exp_estop = d[0];
			ADDR_FPGA_DIAGNOSTIC_LEDS:  exp_led = d[7:0];
			default:
			begin
			end
		endcase
		@(negedge clk_100m);
		data_mosi_rdy = 1'b0;
	endtask

	task automatic read_check(input reg_addr_t a, input reg_word_t e);
		addr     = a;
		exp_miso = e;
		miso_en  = 1'b1;
		@(negedge clk_100m);
		miso_en = 1'b0;
	endtask

	task automatic check_value(input string name, input reg_word_t got, input reg_word_t e);
		val_name = name;
		val_got  = got;
		val_exp  = e;
		val_en   = 1'b1;
		@(negedge clk_100m);
		val_en = 1'b0;
		@(negedge clk_100m);
	endtask

	task automatic wait_1m_rise();
		int n;
		n = 0;
		do
		begin
			@(posedge clk_100m);
			n++;
		end
		while (clk_1m && n < 20);
		do
		begin
			@(posedge clk_100m);
			n++;
		end
		while (!clk_1m && n < 20);
		if (!clk_1m)
			timeout_error("no rising edge on clk_1m");
		@(negedge clk_100m);
	endtask

	// Ticks with the pwm pin high over one PWM period
	task automatic count_pwm_high(output int n1, output int n2);
		n1 = 0;
		n2 = 0;
		repeat (PWM_PERIOD)
		begin
			wait_1m_rise();
			if (fan1_pwm)
				n1++;
			if (fan2_pwm)
				n2++;
		end
	endtask

	task automatic wait_sample_change(output sample_num_t s);
		sample_num_t start;
		int          n;
		addr = ADDR_FPGA_FAN1_TACHO;
		@(negedge clk_100m);
		start = data_miso[23:16];
		n = 0;
		do
		begin
			@(negedge clk_100m);
			n++;
		end
		while (data_miso[23:16] == start && n < 2 * WIN_CYCLES);
		if (data_miso[23:16] == start)
			timeout_error("tacho sample number did not change");
		s = data_miso[23:16];
	endtask

	task automatic pulse_tacho(input int fan, input int n);
		repeat (n)
		begin
			if (fan == 1)
				fan1_tacho = 1'b1;
			else
				fan2_tacho = 1'b1;
			repeat (3) @(negedge clk_100m);
			fan1_tacho = 1'b0;
			fan2_tacho = 1'b0;
			repeat (3) @(negedge clk_100m);
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial
	begin
		reg_word_t   d;
		reg_addr_t   a;
		duty_t       duty;
		int          n1;
		int          n2;
		int          p1;
		int          p2;
		sample_num_t s0;
		sample_num_t s1;

		rst_n_syn      = 1'b0;
		clk_1m         = 1'b0;
		clk_1m_div     = 0;
		addr           = '0;
		data_mosi      = '0;
		data_mosi_rdy  = 1'b0;
		pow            = 1'b0;
		fpga_buttons   = '0;
		drape_sw_state = '0;
		drape_em_state = '0;
		drape_sensor   = '0;
		fan1_tacho     = 1'b0;
		fan2_tacho     = 1'b0;
		exp_right      = 1'b0;
		exp_left       = 1'b0;
		exp_estop      = 1'b0;
		exp_arm        = 1'b0;
		exp_key        = '0;
		exp_led        = 8'hFF;
		pins_en        = 1'b0;
		miso_en        = 1'b0;
		val_en         = 1'b0;
		err_cnt        = 0;
		tests_run      = 0;
		tests_failed   = 0;
		repeat (3) @(negedge clk_100m);
		rst_n_syn = 1'b1;
		pins_en   = 1'b1;

		start_test("reset and identity");
		check_value("fan1_pwm", {31'b0, fan1_pwm}, 32'h0);
		check_value("fan2_pwm", {31'b0, fan2_pwm}, 32'h0);
		read_check(ADDR_FPGA_VER, {16'h0000, FPGA_MAJOR_VER, FPGA_REV});
		read_check(ADDR_FPGA_REV_DATA, {FPGA_REV_YEAR, FPGA_REV_MONTH, FPGA_REV_DAY,
			FPGA_REV_HOUR});
		read_check(ADDR_FPGA_FAN1_TACHO, 32'h0);
		read_check(ADDR_FPGA_FAN2_TACHO, 32'h0);
		read_check(16'h0040, 32'hFFFF_FFFF);
		read_check(16'h0006, 32'hFFFF_FFFF);
		end_test();

		start_test("write and readback");
		for (int r = 0; r < 3; r++)
			for (int i = 0; i < 7; i++)
			begin
				a = writable_addr(i);
				d = $random(seed);
				write_reg(a, d);
				read_check(a, d & field_mask(a));
			end
		end_test();

		start_test("diagnostic e-stop");
		write_reg(ADDR_FPGA_ESTOP_ACTIVATION, 32'h0);
		write_reg(ADDR_FPGA_ESTOP_DIAGNOSTIC, 32'h0000_ABCD);
		write_reg(ADDR_FPGA_ESTOP_ACTIVATION, 32'h8000_0000);
		read_check(ADDR_FPGA_ESTOP_ACTIVATION, 32'h8000_0000);
		write_reg(ADDR_FPGA_ESTOP_ACTIVATION, 32'h7FFF_FFFF);
		write_reg(ADDR_FPGA_ESTOP_ACTIVATION, 32'hFFFF_FFFF);
		write_reg(ADDR_FPGA_ESTOP_DIAGNOSTIC, 32'h0000_ABCC);
		d = $random(seed);
		if (d[15:0] == 16'hABCD)
			d[0] = ~d[0];
		write_reg(ADDR_FPGA_ESTOP_DIAGNOSTIC, d);
		read_check(ADDR_FPGA_ESTOP_DIAGNOSTIC, {16'h0000, d[15:0]});
		write_reg(ADDR_FPGA_ESTOP_DIAGNOSTIC, 32'hFFFF_ABCD);
		write_reg(ADDR_FPGA_ESTOP_ACTIVATION, 32'h0);
		end_test();

		start_test("status inputs");
		for (int r = 0; r < 4; r++)
			for (int i = 0; i < 5; i++)
			begin
				a = ADDR_FPGA_POW_DIAG + reg_addr_t'(4 * i);
				d = $random(seed);
				pow            = d[0];
				fpga_buttons   = d[8:1];
				drape_sw_state = d[10:9];
				drape_em_state = d[12:11];
				drape_sensor   = d[24:13];
				@(negedge clk_100m);
				read_check(a, status_expect(a));
			end
		end_test();

		start_test("fan pwm");
		for (int k = 0; k < 3; k++)
		begin
			duty = (k == 0) ? 8'h00 : (k == 1) ? 8'h40 : 8'hFF;
			write_reg(ADDR_FPGA_FAN1_PWM, {24'b0, duty});
			write_reg(ADDR_FPGA_FAN2_PWM, {24'b0, duty});
			// New duty is latched within one period
			repeat (PWM_PERIOD) wait_1m_rise();
			count_pwm_high(n1, n2);
			d = (duty == 8'hFF) ? PWM_PERIOD : 4 * duty;
			check_value("fan1_pwm high ticks", n1, d);
			check_value("fan2_pwm high ticks", n2, d);
		end
		end_test();

		start_test("fan tacho");
		repeat (2)
		begin
			wait_sample_change(s0);
			p1 = 1 + ($random(seed) & 15);
			p2 = 1 + ($random(seed) & 15);
			pulse_tacho(1, p1);
			pulse_tacho(2, p2);
			wait_sample_change(s1);
			check_value("tacho sample number", {24'b0, s1}, {24'b0, s0 + 8'd1});
			read_check(ADDR_FPGA_FAN1_TACHO, {8'h00, s0 + 8'd1, 16'(p1)});
			read_check(ADDR_FPGA_FAN2_TACHO, {8'h00, s0 + 8'd1, 16'(p2)});
		end
		end_test();

		$display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
